// File: verilog/cu_defines.svh
// Width macros for the multicycle control unit
// Opcode sits in the top bits of the instruction and funct in the bottom bits
// Changing a width here also changes the matching enum widths in the package

`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

//--------------------------------------------------
// Instruction format
//--------------------------------------------------

// Full instruction word
`define CU_DATA_WIDTH 32

// Opcode field at the top of the word
`define CU_OPCODE_WIDTH 6

// Funct field of R-type instructions
`define CU_FUNCT_WIDTH 6

//--------------------------------------------------
// Datapath control
//--------------------------------------------------

// Operation code sent to the ALU
`define CU_ALU_OPRN_WIDTH 5

`endif

// File: verilog/cu_pkg.sv
// Shared types for the control unit
// Enum labels carry a short prefix so that equal names in different enums stay apart

`default_nettype none

`include "cu_defines.svh"

package cu_pkg;

	//--------------------------------------------------
	// Phases and instruction encodings
	//--------------------------------------------------

	// Five-phase cycle of one instruction
	typedef enum logic [2:0] {
		PH_FETCH  = 3'd0,
		PH_DECODE = 3'd1,
		PH_EXE    = 3'd2,
		PH_MEM    = 3'd3,
		PH_WB     = 3'd4
	} proc_phase_t;

	// Supported opcodes, everything else decodes as a no-op
	typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
		OP_RTYPE = `CU_OPCODE_WIDTH'h00,
		OP_J     = `CU_OPCODE_WIDTH'h02,
		OP_JAL   = `CU_OPCODE_WIDTH'h03,
		OP_BEQ   = `CU_OPCODE_WIDTH'h04,
		OP_BNE   = `CU_OPCODE_WIDTH'h05,
		OP_ADDI  = `CU_OPCODE_WIDTH'h08,
		OP_SLTI  = `CU_OPCODE_WIDTH'h0a,
		OP_ANDI  = `CU_OPCODE_WIDTH'h0c,
		OP_ORI   = `CU_OPCODE_WIDTH'h0d,
		OP_LUI   = `CU_OPCODE_WIDTH'h0f,
		OP_MULI  = `CU_OPCODE_WIDTH'h1d,
		OP_LW    = `CU_OPCODE_WIDTH'h23,
		OP_SW    = `CU_OPCODE_WIDTH'h2b
	} opcode_t;

	// R-type funct codes
	typedef enum logic [`CU_FUNCT_WIDTH-1:0] {
		FN_SLL = `CU_FUNCT_WIDTH'h00,
		FN_SRL = `CU_FUNCT_WIDTH'h02,
		FN_JR  = `CU_FUNCT_WIDTH'h08,
		FN_ADD = `CU_FUNCT_WIDTH'h20,
		FN_SUB = `CU_FUNCT_WIDTH'h22,
		FN_AND = `CU_FUNCT_WIDTH'h24,
		FN_OR  = `CU_FUNCT_WIDTH'h25,
		FN_NOR = `CU_FUNCT_WIDTH'h27,
		FN_SLT = `CU_FUNCT_WIDTH'h2a,
		FN_MUL = `CU_FUNCT_WIDTH'h2c
	} funct_t;

	// ALU operation codes as the datapath expects them
	typedef enum logic [`CU_ALU_OPRN_WIDTH-1:0] {
		ALU_NOP = `CU_ALU_OPRN_WIDTH'h00,
		ALU_ADD = `CU_ALU_OPRN_WIDTH'h01,
		ALU_SUB = `CU_ALU_OPRN_WIDTH'h02,
		ALU_MUL = `CU_ALU_OPRN_WIDTH'h03,
		ALU_SRL = `CU_ALU_OPRN_WIDTH'h04,
		ALU_SLL = `CU_ALU_OPRN_WIDTH'h05,
		ALU_AND = `CU_ALU_OPRN_WIDTH'h06,
		ALU_OR  = `CU_ALU_OPRN_WIDTH'h07,
		ALU_NOR = `CU_ALU_OPRN_WIDTH'h08,
		ALU_SLT = `CU_ALU_OPRN_WIDTH'h09
	} alu_oprn_t;

	//--------------------------------------------------
	// Datapath selects
	//--------------------------------------------------

	typedef enum logic [1:0] {OP2_RT, OP2_SHAMT, OP2_SIGN_IMM, OP2_ZERO_IMM} op2_sel_t;
	typedef enum logic [1:0] {WA_RD, WA_RT, WA_R31} wa_sel_t;
	typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_LUI_IMM, WD_PC} wd_sel_t;
	typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;
	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_t;

	// Per-instruction decode result, held until the next accept
	typedef struct packed {
		alu_oprn_t alu_oprn;
		op2_sel_t  op2_sel;
		mem_op_t   mem_op;
		branch_t   branch;
		logic      rf_write;
		wa_sel_t   wa_sel;
		wd_sel_t   wd_sel;
		// Only NEXT, JUMP or REG
		pc_sel_t   jump_sel;
	} decoded_instr_t;

	// Control word seen by the datapath in each phase
	typedef struct packed {
		logic      pc_load;
		pc_sel_t   pc_sel;
		logic      mem_read;
		logic      mem_write;
		logic      mem_addr_from_alu;
		logic      rf_read;
		logic      rf_write;
		wa_sel_t   wa_sel;
		wd_sel_t   wd_sel;
		op2_sel_t  op2_sel;
		alu_oprn_t alu_oprn;
	} ctrl_word_t;

endpackage

`default_nettype wire

// File: verilog/proc_sequencer.sv
// Phase FSM of the multicycle control unit
// Waits in FETCH for instr_valid, the other four phases take one cycle each
// Unused phase encodings recover to FETCH

`timescale 1ns/10ps
`default_nettype none

module proc_sequencer
	import cu_pkg::*;
(
	input  wire logic   CLK,
	input  wire logic   rst_n,
	input  wire logic   instr_valid,
	output logic        instr_ready,
	output logic        accept,
	output proc_phase_t phase
);

	proc_phase_t next_phase;

	//--------------------------------------------------
	// Instruction handshake
	//--------------------------------------------------

	// Ready only while parked in FETCH
	assign instr_ready = (phase == PH_FETCH);

	// Handshake fire, shared with decoder and control word
	assign accept = instr_ready & instr_valid;

	//--------------------------------------------------
	// Phase register
	//--------------------------------------------------

	// Fixed order, only FETCH can stall
	always_comb begin
		case (phase)
			PH_FETCH:  next_phase = accept ? PH_DECODE : PH_FETCH;
			PH_DECODE: next_phase = PH_EXE;
			PH_EXE:    next_phase = PH_MEM;
			PH_MEM:    next_phase = PH_WB;
			PH_WB:     next_phase = PH_FETCH;
			default:   next_phase = PH_FETCH;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_FETCH;
		end else begin
			phase <= next_phase;
		end
	end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
// Instruction register and opcode/funct decode
// instr is captured on the accept edge only, dec follows the register combinationally
// Unknown opcodes or functs give a no-op with no writes and PC_NEXT

`timescale 1ns/10ps
`default_nettype none

`include "cu_defines.svh"

module instr_decoder
	import cu_pkg::*;
(
	input  wire logic                      CLK,
	input  wire logic                      rst_n,
	input  wire logic                      accept,
	input  wire logic [`CU_DATA_WIDTH-1:0] instr,
	output decoded_instr_t                 dec
);

	// Baseline decode, also the result for anything unsupported
	localparam decoded_instr_t DEC_NOP = '{
		alu_oprn: ALU_NOP,
		op2_sel:  OP2_RT,
		mem_op:   MEM_NONE,
		branch:   BR_NONE,
		rf_write: 1'b0,
		wa_sel:   WA_RD,
		wd_sel:   WD_ALU,
		jump_sel: PC_NEXT
	};

	logic [`CU_DATA_WIDTH-1:0] instr_reg;
	opcode_t                   opcode;
	funct_t                    funct;

	//--------------------------------------------------
	// Instruction register
	//--------------------------------------------------

	// All zeros reads as sll r0 and is never used before a fetch
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			instr_reg <= '0;
		end else if (accept) begin
			instr_reg <= instr;
		end
	end

	// Field extraction
	assign opcode = opcode_t'(instr_reg[`CU_DATA_WIDTH-1 -: `CU_OPCODE_WIDTH]);
	assign funct  = funct_t'(instr_reg[`CU_FUNCT_WIDTH-1:0]);

	//--------------------------------------------------
	// Decode
	//--------------------------------------------------

	always_comb begin
		dec = DEC_NOP;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD:  dec.alu_oprn = ALU_ADD;
					FN_SUB:  dec.alu_oprn = ALU_SUB;
					FN_MUL:  dec.alu_oprn = ALU_MUL;
					FN_AND:  dec.alu_oprn = ALU_AND;
					FN_OR:   dec.alu_oprn = ALU_OR;
					FN_NOR:  dec.alu_oprn = ALU_NOR;
					FN_SLT:  dec.alu_oprn = ALU_SLT;
					FN_SLL:  dec.alu_oprn = ALU_SLL;
					FN_SRL:  dec.alu_oprn = ALU_SRL;
					// jr jumps to R[rs] and writes nothing
					FN_JR:   dec.jump_sel = PC_REG;
					default: dec.alu_oprn = ALU_NOP;
				endcase
				// Every ALU funct writes rd with the ALU result
				if (dec.alu_oprn != ALU_NOP) begin
					dec.rf_write = 1'b1;
					dec.wa_sel   = WA_RD;
					dec.wd_sel   = WD_ALU;
				end
				// Shifts take shamt as operand 2
				if (funct == FN_SLL || funct == FN_SRL) begin
					dec.op2_sel = OP2_SHAMT;
				end
			end
			// Arithmetic immediates, sign extended, result to rt
			OP_ADDI, OP_MULI, OP_SLTI: begin
				dec.op2_sel  = OP2_SIGN_IMM;
				dec.rf_write = 1'b1;
				dec.wa_sel   = WA_RT;
				dec.alu_oprn = (opcode == OP_ADDI) ? ALU_ADD :
					(opcode == OP_MULI) ? ALU_MUL : ALU_SLT;
			end
			// Logical immediates, zero extended
			OP_ANDI, OP_ORI: begin
				dec.op2_sel  = OP2_ZERO_IMM;
				dec.rf_write = 1'b1;
				dec.wa_sel   = WA_RT;
				dec.alu_oprn = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
			end
			// Upper immediate bypasses the ALU
			OP_LUI: begin
				dec.op2_sel  = OP2_SIGN_IMM;
				dec.rf_write = 1'b1;
				dec.wa_sel   = WA_RT;
				dec.wd_sel   = WD_LUI_IMM;
			end
			// Compare by subtraction, zero flag decides in WB
			OP_BEQ, OP_BNE: begin
				dec.alu_oprn = ALU_SUB;
				dec.op2_sel  = OP2_RT;
				dec.branch   = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
			end
			// Address is rs plus sign-extended offset
			OP_LW: begin
				dec.alu_oprn = ALU_ADD;
				dec.op2_sel  = OP2_SIGN_IMM;
				dec.mem_op   = MEM_LOAD;
				dec.rf_write = 1'b1;
				dec.wa_sel   = WA_RT;
				dec.wd_sel   = WD_MEM;
			end
			OP_SW: begin
				dec.alu_oprn = ALU_ADD;
				dec.op2_sel  = OP2_SIGN_IMM;
				dec.mem_op   = MEM_STORE;
			end
			OP_J: begin
				dec.jump_sel = PC_JUMP;
			end
			// Link address goes to r31
			OP_JAL: begin
				dec.jump_sel = PC_JUMP;
				dec.rf_write = 1'b1;
				dec.wa_sel   = WA_R31;
				dec.wd_sel   = WD_PC;
			end
			default: dec = DEC_NOP;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/ctrl_word_gen.sv
// Control word for the datapath, purely combinational
// Valid during the phase it belongs to, the zero flag only matters in WB
// Fields not driven in a phase stay at 0, RT or NEXT

`timescale 1ns/10ps
`default_nettype none

module ctrl_word_gen
	import cu_pkg::*;
(
	input  wire proc_phase_t    phase,
	input  wire decoded_instr_t dec,
	input  wire logic           zero,
	output ctrl_word_t          ctrl
);

	// All strobes off, selects at their first value
	localparam ctrl_word_t CTRL_IDLE = '{
		pc_load:           1'b0,
		pc_sel:            PC_NEXT,
		mem_read:          1'b0,
		mem_write:         1'b0,
		mem_addr_from_alu: 1'b0,
		rf_read:           1'b0,
		rf_write:          1'b0,
		wa_sel:            WA_RD,
		wd_sel:            WD_ALU,
		op2_sel:           OP2_RT,
		alu_oprn:          ALU_NOP
	};

	logic take_branch;

	//--------------------------------------------------
	// Branch decision
	//--------------------------------------------------

	// Consumed in WB only
	always_comb begin
		case (dec.branch)
			BR_EQ:   take_branch = zero;
			BR_NE:   take_branch = ~zero;
			default: take_branch = 1'b0;
		endcase
	end

	//--------------------------------------------------
	// Per-phase control word
	//--------------------------------------------------

	always_comb begin
		ctrl = CTRL_IDLE;
		case (phase)
			// Operands read, ALU set up
			PH_EXE: begin
				ctrl.mem_read = 1'b1;
				ctrl.rf_read  = 1'b1;
				ctrl.alu_oprn = dec.alu_oprn;
				ctrl.op2_sel  = dec.op2_sel;
			end
			// ALU held so the address stays stable
			PH_MEM: begin
				ctrl.alu_oprn = dec.alu_oprn;
				ctrl.op2_sel  = dec.op2_sel;
				case (dec.mem_op)
					MEM_LOAD: begin
						ctrl.mem_read          = 1'b1;
						ctrl.mem_addr_from_alu = 1'b1;
					end
					MEM_STORE: begin
						ctrl.mem_write         = 1'b1;
						ctrl.mem_addr_from_alu = 1'b1;
					end
					default: ctrl.mem_read = 1'b1;
				endcase
			end
			// Register write back and PC update
			PH_WB: begin
				ctrl.alu_oprn = dec.alu_oprn;
				ctrl.op2_sel  = dec.op2_sel;
				ctrl.pc_load  = 1'b1;
				ctrl.rf_write = dec.rf_write;
				ctrl.rf_read  = ~dec.rf_write;
				ctrl.wa_sel   = dec.wa_sel;
				ctrl.wd_sel   = dec.wd_sel;
				// Taken branch wins over the jump select
				ctrl.pc_sel   = take_branch ? PC_BRANCH : dec.jump_sel;
			end
			// FETCH and DECODE read memory and registers at the PC address
			default: begin
				ctrl.mem_read = 1'b1;
				ctrl.rf_read  = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
// Top of the multicycle control unit, one instruction in flight
// instr must stay stable while instr_valid waits for instr_ready
// Sequencer, decoder and control word generator only

`timescale 1ns/10ps
`default_nettype none

`include "cu_defines.svh"

module control_unit
	import cu_pkg::*;
(
	input  wire logic                      CLK,
	input  wire logic                      rst_n,
	input  wire logic [`CU_DATA_WIDTH-1:0] instr,
	input  wire logic                      instr_valid,
	output logic                           instr_ready,
	input  wire logic                      zero,
	output proc_phase_t                    phase,
	output ctrl_word_t                     ctrl
);

	// Handshake fire from the sequencer
	logic           accept;
	// Decoded fields of the held instruction
	decoded_instr_t dec;

	//--------------------------------------------------
	// Phase FSM and handshake
	//--------------------------------------------------
	proc_sequencer sequencer_inst (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.accept      (accept),
		.phase       (phase)
	);

	// Instruction register and decode
	instr_decoder decoder_inst (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.accept (accept),
		.instr  (instr),
		.dec    (dec)
	);

	// Datapath control word
	ctrl_word_gen ctrl_gen_inst (
		.phase (phase),
		.dec   (dec),
		.zero  (zero),
		.ctrl  (ctrl)
	);

endmodule

`default_nettype wire

// File: verification/control_unit_tb.sv
// Directed testbench for the multicycle control unit
// Inputs change 5 ns after the rising edge and outputs are sampled on the falling edge
// Expected control words come from the per-phase and decode rules

`timescale 1ns/10ps
`default_nettype none

`include "cu_defines.svh"

module control_unit_tb
	import cu_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	// 9 R-type, 8 I-type, 4 branch, 5 jump/unknown, 4 after back-pressure
	localparam int NUM_INSTR    = 30;
	localparam int NUM_GAPS     = 4;
	localparam int MAX_GAP      = 8;
	localparam int MARGIN       = 100;
	localparam int WATCHDOG_CYC = RESET_CYCLES + NUM_INSTR * 5 + NUM_GAPS * MAX_GAP + MARGIN;

	logic                      CLK;
	logic                      rst_n;
	logic [`CU_DATA_WIDTH-1:0] instr;
	logic                      instr_valid;
	logic                      instr_ready;
	logic                      zero;
	proc_phase_t               phase;
	ctrl_word_t                ctrl;

	logic [31:0] lfsr_state;
	int          check_count;
	int          error_count;
	int          test_count;

	control_unit control_unit_inst (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.zero        (zero),
		.phase       (phase),
		.ctrl        (ctrl)
	);

	// 100 ns clock
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	//--------------------------------------------------
	// Random fields and expected values
	//--------------------------------------------------

	// Taps 32, 22, 2 and 1 with one step per returned bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// R-type with random rs, rt, rd, shamt
	function automatic logic [31:0] encode_r(input logic [5:0] fn);
		return {6'h00, 20'(lfsr_bits(20)), fn};
	endfunction

	// I-type with random rs, rt, immediate
	function automatic logic [31:0] encode_i(input logic [5:0] op);
		return {op, 26'(lfsr_bits(26))};
	endfunction

	function automatic decoded_instr_t make_dec(input alu_oprn_t alu, input op2_sel_t op2,
		input mem_op_t mem, input logic wr, input wa_sel_t wa, input wd_sel_t wd,
		input pc_sel_t jmp);
		decoded_instr_t d;
		d = '0;
		d.alu_oprn = alu;
		d.op2_sel  = op2;
		d.mem_op   = mem;
		d.rf_write = wr;
		d.wa_sel   = wa;
		d.wd_sel   = wd;
		d.jump_sel = jmp;
		return d;
	endfunction

	// FETCH and DECODE word
	function automatic ctrl_word_t fetch_word();
		ctrl_word_t c;
		c = '0;
		c.mem_read = 1'b1;
		c.rf_read  = 1'b1;
		return c;
	endfunction

	// Per-phase rule with the WB pc_sel supplied by the caller
	function automatic ctrl_word_t expected_ctrl(input proc_phase_t ph, input decoded_instr_t d,
		input pc_sel_t pc);
		ctrl_word_t c;
		c = fetch_word();
		if (ph == PH_EXE) begin
			c.alu_oprn = d.alu_oprn;
			c.op2_sel  = d.op2_sel;
		end else if (ph == PH_MEM) begin
			c.alu_oprn = d.alu_oprn;
			c.op2_sel  = d.op2_sel;
			c.rf_read  = 1'b0;
			if (d.mem_op == MEM_LOAD) begin
				c.mem_addr_from_alu = 1'b1;
			end else if (d.mem_op == MEM_STORE) begin
				c.mem_read          = 1'b0;
				c.mem_write         = 1'b1;
				c.mem_addr_from_alu = 1'b1;
			end
		end else if (ph == PH_WB) begin
			c.mem_read = 1'b0;
			c.alu_oprn = d.alu_oprn;
			c.op2_sel  = d.op2_sel;
			c.pc_load  = 1'b1;
			c.pc_sel   = pc;
			c.rf_write = d.rf_write;
			c.rf_read  = ~d.rf_write;
			c.wa_sel   = d.wa_sel;
			c.wd_sel   = d.wd_sel;
		end
		return c;
	endfunction

	//--------------------------------------------------
	// Compare tasks
	//--------------------------------------------------

	task automatic check_phase(input string tag, input proc_phase_t exp, input proc_phase_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch in %s: phase expected %0d actual %0d", tag, exp, act);
		end
	endtask

	task automatic check_ctrl(input string tag, input ctrl_word_t exp, input ctrl_word_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch in %s: ctrl expected %h actual %h", tag, exp, act);
		end
	endtask

	task automatic check_ready(input string tag, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch in %s: instr_ready expected %b actual %b", tag, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("%s finished with %0d errors", name, error_count - errs_before);
	endtask

	//--------------------------------------------------
	// One instruction through all five phases
	//--------------------------------------------------

	// Entered and left at the drive point of a FETCH cycle
	task automatic run_instr(input string name, input logic [31:0] word,
		input decoded_instr_t d, input logic zero_wb, input pc_sel_t pc);
		proc_phase_t ph_list[4];
		string       ph_text[4];
		int          waited;
		ph_list = '{PH_DECODE, PH_EXE, PH_MEM, PH_WB};
		ph_text = '{"DECODE", "EXE", "MEM", "WB"};
		waited  = 0;
		while (instr_ready !== 1'b1 && waited < 10) begin
			@(posedge CLK);
			#5;
			waited++;
		end
		if (instr_ready !== 1'b1) begin
			error_count++;
			$display("Error in %s: instr_ready did not rise within 10 cycles", name);
		end
		instr       = word;
		instr_valid = 1'b1;
		zero        = ~zero_wb;
		@(negedge CLK);
		check_phase({name, " FETCH"}, PH_FETCH, phase);
		check_ready({name, " FETCH"}, 1'b1, instr_ready);
		check_ctrl({name, " FETCH"}, fetch_word(), ctrl);
		// Accept edge followed by a scrambled instr to show the register holds
		@(posedge CLK);
		#5;
		instr_valid = 1'b0;
		instr       = lfsr_bits(32);
		for (int i = 0; i < 4; i++) begin
			if (ph_list[i] == PH_WB) begin
				zero = zero_wb;
			end
			@(negedge CLK);
			check_phase({name, " ", ph_text[i]}, ph_list[i], phase);
			check_ready({name, " ", ph_text[i]}, 1'b0, instr_ready);
			check_ctrl({name, " ", ph_text[i]}, expected_ctrl(ph_list[i], d, pc), ctrl);
			@(posedge CLK);
			#5;
		end
		// Back in FETCH five cycles after the accept cycle
		check_ready({name, " next fetch"}, 1'b1, instr_ready);
	endtask

	//--------------------------------------------------
	// Directed tests
	//--------------------------------------------------

	task automatic test_reset();
		int errs;
		errs = error_count;
		@(negedge CLK);
		check_phase("reset", PH_FETCH, phase);
		check_ready("reset", 1'b1, instr_ready);
		check_ctrl("reset", fetch_word(), ctrl);
		@(posedge CLK);
		#5;
		report_test("test_reset", errs);
	endtask

	task automatic rtype_case(input string name, input logic [5:0] fn, input alu_oprn_t alu,
		input op2_sel_t op2);
		run_instr(name, encode_r(fn), make_dec(alu, op2, MEM_NONE, 1'b1, WA_RD, WD_ALU, PC_NEXT),
			1'(lfsr_bits(1)), PC_NEXT);
	endtask

	task automatic test_rtype();
		int errs;
		errs = error_count;
		rtype_case("add", 6'h20, ALU_ADD, OP2_RT);
		rtype_case("sub", 6'h22, ALU_SUB, OP2_RT);
		rtype_case("mul", 6'h2c, ALU_MUL, OP2_RT);
		rtype_case("and", 6'h24, ALU_AND, OP2_RT);
		rtype_case("or", 6'h25, ALU_OR, OP2_RT);
		rtype_case("nor", 6'h27, ALU_NOR, OP2_RT);
		rtype_case("slt", 6'h2a, ALU_SLT, OP2_RT);
		rtype_case("sll", 6'h00, ALU_SLL, OP2_SHAMT);
		rtype_case("srl", 6'h02, ALU_SRL, OP2_SHAMT);
		report_test("test_rtype", errs);
	endtask

	task automatic itype_case(input string name, input logic [5:0] op, input decoded_instr_t d);
		run_instr(name, encode_i(op), d, 1'(lfsr_bits(1)), PC_NEXT);
	endtask

	task automatic test_itype();
		int errs;
		errs = error_count;
		itype_case("addi", 6'h08,
			make_dec(ALU_ADD, OP2_SIGN_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT));
		itype_case("muli", 6'h1d,
			make_dec(ALU_MUL, OP2_SIGN_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT));
		itype_case("andi", 6'h0c,
			make_dec(ALU_AND, OP2_ZERO_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT));
		itype_case("ori", 6'h0d,
			make_dec(ALU_OR, OP2_ZERO_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT));
		itype_case("slti", 6'h0a,
			make_dec(ALU_SLT, OP2_SIGN_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT));
		itype_case("lui", 6'h0f,
			make_dec(ALU_NOP, OP2_SIGN_IMM, MEM_NONE, 1'b1, WA_RT, WD_LUI_IMM, PC_NEXT));
		itype_case("lw", 6'h23,
			make_dec(ALU_ADD, OP2_SIGN_IMM, MEM_LOAD, 1'b1, WA_RT, WD_MEM, PC_NEXT));
		itype_case("sw", 6'h2b,
			make_dec(ALU_ADD, OP2_SIGN_IMM, MEM_STORE, 1'b0, WA_RD, WD_ALU, PC_NEXT));
		report_test("test_itype", errs);
	endtask

	// Taken when beq sees zero or bne sees nonzero
	task automatic test_branch();
		int      errs;
		logic    is_eq;
		logic    z;
		pc_sel_t pc;
		errs = error_count;
		for (int i = 0; i < 4; i++) begin
			is_eq = (i < 2);
			z     = i[0];
			pc    = ((is_eq && z) || (!is_eq && !z)) ? PC_BRANCH : PC_NEXT;
			run_instr(is_eq ? (z ? "beq z1" : "beq z0") : (z ? "bne z1" : "bne z0"),
				encode_i(is_eq ? 6'h04 : 6'h05),
				make_dec(ALU_SUB, OP2_RT, MEM_NONE, 1'b0, WA_RD, WD_ALU, PC_NEXT), z, pc);
		end
		report_test("test_branch", errs);
	endtask

	task automatic test_jump();
		int errs;
		errs = error_count;
		run_instr("j", encode_i(6'h02),
			make_dec(ALU_NOP, OP2_RT, MEM_NONE, 1'b0, WA_RD, WD_ALU, PC_JUMP),
			1'(lfsr_bits(1)), PC_JUMP);
		run_instr("jal", encode_i(6'h03),
			make_dec(ALU_NOP, OP2_RT, MEM_NONE, 1'b1, WA_R31, WD_PC, PC_JUMP),
			1'(lfsr_bits(1)), PC_JUMP);
		run_instr("jr", encode_r(6'h08),
			make_dec(ALU_NOP, OP2_RT, MEM_NONE, 1'b0, WA_RD, WD_ALU, PC_REG),
			1'(lfsr_bits(1)), PC_REG);
		// Opcode 3f and funct 3f are both unused
		run_instr("unknown opcode", encode_i(6'h3f),
			make_dec(ALU_NOP, OP2_RT, MEM_NONE, 1'b0, WA_RD, WD_ALU, PC_NEXT),
			1'(lfsr_bits(1)), PC_NEXT);
		run_instr("unknown funct", encode_r(6'h3f),
			make_dec(ALU_NOP, OP2_RT, MEM_NONE, 1'b0, WA_RD, WD_ALU, PC_NEXT),
			1'(lfsr_bits(1)), PC_NEXT);
		report_test("test_jump", errs);
	endtask

	// Idle FETCH for 1 to 8 cycles before each instruction
	task automatic test_backpressure();
		int errs;
		int gap;
		errs = error_count;
		for (int g = 0; g < NUM_GAPS; g++) begin
			gap = int'(lfsr_bits(3)) + 1;
			instr_valid = 1'b0;
			for (int c = 0; c < gap; c++) begin
				@(negedge CLK);
				check_phase("backpressure wait", PH_FETCH, phase);
				check_ready("backpressure wait", 1'b1, instr_ready);
				check_ctrl("backpressure wait", fetch_word(), ctrl);
				@(posedge CLK);
				#5;
			end
			run_instr("backpressure addi", encode_i(6'h08),
				make_dec(ALU_ADD, OP2_SIGN_IMM, MEM_NONE, 1'b1, WA_RT, WD_ALU, PC_NEXT),
				1'b0, PC_NEXT);
		end
		report_test("test_backpressure", errs);
	endtask

	//--------------------------------------------------
	// Watchdog and main sequence
	//--------------------------------------------------

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Error: watchdog expired after %0d cycles, the DUT stopped responding",
			WATCHDOG_CYC);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		CLK         = 1'b0;
		rst_n       = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		zero        = 1'b0;
		lfsr_state  = 32'hb02a_9549;
		check_count = 0;
		error_count = 0;
		test_count  = 0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#5;
		rst_n = 1'b1;

		test_reset();
		test_rtype();
		test_itype();
		test_branch();
		test_jump();
		test_backpressure();

		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/cu_pkg.sv
verilog/proc_sequencer.sv
verilog/instr_decoder.sv
verilog/ctrl_word_gen.sv
verilog/control_unit.sv
verification/control_unit_tb.sv
